//--- Bender.yml
package:
  name: accelBuf

sources:
  - include_dirs:
      - src
    files:
      - src/accelPkg.sv
      - src/sampleInBuf.sv
      - src/cplxScaler.sv
      - src/sampleOutBuf.sv
      - src/ctrlRegsAxil.sv
      - src/accelBufTop.sv
  - target: test
    include_dirs:
      - src
      - tests
    files:
      - tests/accelBufTb.sv

//--- accelBufTop.f
+incdir+src
+incdir+tests
src/accelPkg.sv
src/sampleInBuf.sv
src/cplxScaler.sv
src/sampleOutBuf.sv
src/ctrlRegsAxil.sv
src/accelBufTop.sv
tests/accelBufTb.sv

//--- src/accelBufTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "accelBuf_params.svh"

module accelBufTop import accelPkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst,
    // memory read side
    input  wire memBeat_t                  memInData,
    input  wire logic                      memInValid,
    output      logic                      memInReady,
    // memory write side
    output      memBeat_t                  memOutData,
    output      logic                      memOutValid,
    input  wire logic                      memOutReady,
    // host register bus
    input  wire logic [`ACCEL_AXIL_AW-1:0] axilAwaddr,
    input  wire logic                      axilAwvalid,
    output      logic                      axilAwready,
    input  wire logic [31:0]               axilWdata,
    input  wire logic [3:0]                axilWstrb,
    input  wire logic                      axilWvalid,
    output      logic                      axilWready,
    output      axilResp_t                 axilBresp,
    output      logic                      axilBvalid,
    input  wire logic                      axilBready,
    input  wire logic [`ACCEL_AXIL_AW-1:0] axilAraddr,
    input  wire logic                      axilArvalid,
    output      logic                      axilArready,
    output      logic [31:0]               axilRdata,
    output      axilResp_t                 axilRresp,
    output      logic                      axilRvalid,
    input  wire logic                      axilRready
);

    cplxSample_t        inSample;
    logic               inValid;
    logic               inReady;
    cplxSample_t        outSample;
    logic               outValid;
    logic               outReady;
    logic               run;
    logic               full;
    logic               frameDone;
    logic signed [31:0] coefRe;
    logic signed [31:0] coefIm;

    sampleInBuf i_inBuf (
        .clk, .rst,
        .memInData, .memInValid, .memInReady,
        .run,
        .inSample, .inValid, .inReady,
        .full
    );

    cplxScaler i_scaler (
        .clk, .rst,
        .inSample, .inValid, .inReady,
        .coefRe, .coefIm,
        .outSample, .outValid, .outReady
    );

    sampleOutBuf i_outBuf (
        .clk, .rst,
        .outSample, .outValid, .outReady,
        .memOutData, .memOutValid, .memOutReady,
        .frameDone
    );

    ctrlRegsAxil i_regs (
        .clk, .rst,
        .axilAwaddr, .axilAwvalid, .axilAwready,
        .axilWdata, .axilWstrb, .axilWvalid, .axilWready,
        .axilBresp, .axilBvalid, .axilBready,
        .axilAraddr, .axilArvalid, .axilArready,
        .axilRdata, .axilRresp, .axilRvalid, .axilRready,
        .run, .coefRe, .coefIm,
        .frameDone, .full
    );

endmodule

`default_nettype wire

//--- src/accelBuf_params.svh
`ifndef ACCEL_BUF_PARAMS_SVH
`define ACCEL_BUF_PARAMS_SVH

// frame geometry
`define ACCEL_FRAME_SAMPLES 1024
`define ACCEL_BEAT_LANES    8

// Q1.30 coefficient, so 1.0 is 0x40000000
`define ACCEL_COEF_FRAC     30

// register bus address width and byte offsets
`define ACCEL_AXIL_AW       5
`define ACCEL_REG_CTRL      5'h00
`define ACCEL_REG_COEF_RE   5'h04
`define ACCEL_REG_COEF_IM   5'h08
`define ACCEL_REG_STATUS    5'h0C
`define ACCEL_REG_FRAMES    5'h10

`endif

//--- src/accelPkg.sv
`default_nettype none

`include "accelBuf_params.svh"

package accelPkg;

    // one complex sample, imaginary half on top
    typedef struct packed {
        logic signed [31:0] im;
        logic signed [31:0] re;
    } cplxSample_t;

    // memory beat, lane 0 is the earliest sample and sits in bits [63:0]
    typedef cplxSample_t [`ACCEL_BEAT_LANES-1:0] memBeat_t;

    // position of a sample within a frame
    typedef logic [$clog2(`ACCEL_FRAME_SAMPLES)-1:0] sampleIdx_t;

    // position of a beat within a frame
    typedef logic [$clog2(`ACCEL_FRAME_SAMPLES / `ACCEL_BEAT_LANES)-1:0] beatIdx_t;

    // subset of the AXI response codes we actually return
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axilResp_t;

endpackage

`default_nettype wire

//--- src/cplxScaler.sv
`timescale 1ns/1ps
`default_nettype none

`include "accelBuf_params.svh"

module cplxScaler import accelPkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire cplxSample_t        inSample,
    input  wire logic               inValid,
    output      logic               inReady,
    input  wire logic signed [31:0] coefRe,
    input  wire logic signed [31:0] coefIm,
    output      cplxSample_t        outSample,
    output      logic               outValid,
    input  wire logic               outReady
);

    localparam int FRAC = `ACCEL_COEF_FRAC;

    logic signed [63:0] pReRe;
    logic signed [63:0] pImIm;
    logic signed [63:0] pReIm;
    logic signed [63:0] pImRe;
    logic signed [63:0] sumRe;
    logic signed [63:0] sumIm;
    logic               s1Valid;
    logic               advance;

    // both stages move together, otherwise everything holds
    assign advance = outReady || !outValid;
    assign inReady = advance;

    // low bits of the 64-bit wrap are exact, so no guard bit needed
    assign sumRe = pReRe - pImIm;
    assign sumIm = pReIm + pImRe;

    // stage 1: the four partial products
    always_ff @(posedge clk) begin
        if (advance) begin
            pReRe <= $signed(inSample.re) * coefRe;
            pImIm <= $signed(inSample.im) * coefIm;
            pReIm <= $signed(inSample.re) * coefIm;
            pImRe <= $signed(inSample.im) * coefRe;
        end
    end

    // stage 2: combine, shift out the fraction, keep 32 bits
    always_ff @(posedge clk) begin
        if (advance) begin
            outSample.re <= sumRe[FRAC +: 32];
            outSample.im <= sumIm[FRAC +: 32];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid  <= 1'b0;
            outValid <= 1'b0;
        end else if (advance) begin
            s1Valid  <= inValid;
            outValid <= s1Valid;
        end
    end

endmodule

`default_nettype wire

//--- src/ctrlRegsAxil.sv
`timescale 1ns/1ps
`default_nettype none

`include "accelBuf_params.svh"

module ctrlRegsAxil import accelPkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic [`ACCEL_AXIL_AW-1:0] axilAwaddr,
    input  wire logic                      axilAwvalid,
    output      logic                      axilAwready,
    input  wire logic [31:0]               axilWdata,
    input  wire logic [3:0]                axilWstrb,
    input  wire logic                      axilWvalid,
    output      logic                      axilWready,
    output      axilResp_t                 axilBresp,
    output      logic                      axilBvalid,
    input  wire logic                      axilBready,
    input  wire logic [`ACCEL_AXIL_AW-1:0] axilAraddr,
    input  wire logic                      axilArvalid,
    output      logic                      axilArready,
    output      logic [31:0]               axilRdata,
    output      axilResp_t                 axilRresp,
    output      logic                      axilRvalid,
    input  wire logic                      axilRready,
    output      logic                      run,
    output      logic signed [31:0]        coefRe,
    output      logic signed [31:0]        coefIm,
    input  wire logic                      frameDone,
    input  wire logic                      full
);

    localparam int AW = `ACCEL_AXIL_AW;
    localparam logic signed [31:0] COEF_ONE = 32'sd1 <<< `ACCEL_COEF_FRAC;

    logic          awPending;
    logic [AW-1:0] awAddrQ;
    logic          wPending;
    logic [31:0]   wDataQ;
    logic [3:0]    wStrbQ;
    logic          doWrite;
    logic [AW-1:0] wrAddr;
    logic [AW-1:0] rdAddr;
    logic          wrMapped;
    logic [31:0]   rdMux;
    logic          rdMapped;
    logic          done;
    logic [31:0]   frameCnt;

    // each channel takes one transfer and holds it until the write fires
    assign axilAwready = !awPending;
    assign axilWready  = !wPending;
    assign axilArready = !axilRvalid;
    assign doWrite     = awPending && wPending && !axilBvalid;

    // registers are word aligned, ignore the byte lane bits
    assign wrAddr = {awAddrQ[AW-1:2], 2'b00};
    assign rdAddr = {axilAraddr[AW-1:2], 2'b00};

    always_comb begin
        case (wrAddr)
            `ACCEL_REG_CTRL, `ACCEL_REG_COEF_RE, `ACCEL_REG_COEF_IM,
            `ACCEL_REG_STATUS, `ACCEL_REG_FRAMES: wrMapped = 1'b1;
            default: wrMapped = 1'b0;
        endcase
    end

    always_comb begin
        rdMux    = '0;
        rdMapped = 1'b1;
        case (rdAddr)
            `ACCEL_REG_CTRL:    rdMux = {31'b0, run};
            `ACCEL_REG_COEF_RE: rdMux = coefRe;
            `ACCEL_REG_COEF_IM: rdMux = coefIm;
            `ACCEL_REG_STATUS:  rdMux = {29'b0, full, done, run};
            `ACCEL_REG_FRAMES:  rdMux = frameCnt;
            default:            rdMapped = 1'b0;
        endcase
    end

    // address and data capture
    always_ff @(posedge clk) begin
        if (axilAwvalid && axilAwready) begin
            awAddrQ <= axilAwaddr;
        end
        if (axilWvalid && axilWready) begin
            wDataQ <= axilWdata;
            wStrbQ <= axilWstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awPending  <= 1'b0;
            wPending   <= 1'b0;
            axilBvalid <= 1'b0;
            axilBresp  <= OKAY;
        end else begin
            if (axilAwvalid && axilAwready) begin
                awPending <= 1'b1;
            end
            if (axilWvalid && axilWready) begin
                wPending <= 1'b1;
            end
            if (doWrite) begin
                awPending  <= 1'b0;
                wPending   <= 1'b0;
                axilBvalid <= 1'b1;
                axilBresp  <= wrMapped ? OKAY : SLVERR;
            end else if (axilBvalid && axilBready) begin
                axilBvalid <= 1'b0;
            end
        end
    end

    // register file; STATUS and FRAMES writes fall through untouched
    always_ff @(posedge clk) begin
        if (rst) begin
            run      <= 1'b0;
            done     <= 1'b0;
            coefRe   <= COEF_ONE;
            coefIm   <= '0;
            frameCnt <= '0;
        end else begin
            if (doWrite) begin
                case (wrAddr)
                    `ACCEL_REG_CTRL: begin
                        // start is ignored while a frame is running
                        if (wStrbQ[0] && wDataQ[0] && !run) begin
                            run  <= 1'b1;
                            done <= 1'b0;
                        end
                    end
                    `ACCEL_REG_COEF_RE: begin
                        for (int b = 0; b < 4; b++) begin
                            if (wStrbQ[b]) begin
                                coefRe[8*b +: 8] <= wDataQ[8*b +: 8];
                            end
                        end
                    end
                    `ACCEL_REG_COEF_IM: begin
                        for (int b = 0; b < 4; b++) begin
                            if (wStrbQ[b]) begin
                                coefIm[8*b +: 8] <= wDataQ[8*b +: 8];
                            end
                        end
                    end
                    default: ;
                endcase
            end

            // run is high here, so this never races a start
            if (frameDone) begin
                run      <= 1'b0;
                done     <= 1'b1;
                frameCnt <= frameCnt + 1'b1;
            end
        end
    end

    // read channel, response one cycle after the AR handshake
    always_ff @(posedge clk) begin
        if (axilArvalid && axilArready) begin
            axilRdata <= rdMux;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            axilRvalid <= 1'b0;
            axilRresp  <= OKAY;
        end else if (axilArvalid && axilArready) begin
            axilRvalid <= 1'b1;
            axilRresp  <= rdMapped ? OKAY : SLVERR;
        end else if (axilRvalid && axilRready) begin
            axilRvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/sampleInBuf.sv
`timescale 1ns/1ps
`default_nettype none

`include "accelBuf_params.svh"

module sampleInBuf import accelPkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire memBeat_t    memInData,
    input  wire logic        memInValid,
    output      logic        memInReady,
    input  wire logic        run,
    output      cplxSample_t inSample,
    output      logic        inValid,
    input  wire logic        inReady,
    output      logic        full
);

    localparam int LANES = `ACCEL_BEAT_LANES;
    localparam int LANE_W = $clog2(LANES);
    localparam beatIdx_t LAST_BEAT = beatIdx_t'(`ACCEL_FRAME_SAMPLES / LANES - 1);
    localparam sampleIdx_t LAST_SAMPLE = sampleIdx_t'(`ACCEL_FRAME_SAMPLES - 1);

    cplxSample_t frameMem [`ACCEL_FRAME_SAMPLES];

    beatIdx_t   wrBeat;
    sampleIdx_t rdIdx;
    sampleIdx_t nextIdx;
    logic       beatIn;
    logic       deq;
    logic       loadEn;

    // accept beats whenever there is room for a whole frame
    assign memInReady = !full;
    assign beatIn     = memInValid && memInReady;
    assign deq        = inValid && inReady;

    // refill the output register on each dequeue, or prime it on start
    assign nextIdx = deq ? rdIdx + 1'b1 : rdIdx;
    assign loadEn  = deq ? (rdIdx != LAST_SAMPLE) : (!inValid && full && run);

    // one beat lands as eight consecutive samples
    always_ff @(posedge clk) begin
        if (beatIn) begin
            for (int lane = 0; lane < LANES; lane++) begin
                frameMem[{wrBeat, LANE_W'(lane)}] <= memInData[lane];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadEn) begin
            inSample <= frameMem[nextIdx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrBeat  <= '0;
            rdIdx   <= '0;
            full    <= 1'b0;
            inValid <= 1'b0;
        end else begin
            if (beatIn) begin
                // beat counter wraps back to 0 on the last beat
                wrBeat <= wrBeat + 1'b1;
                if (wrBeat == LAST_BEAT) begin
                    full <= 1'b1;
                end
            end

            if (deq) begin
                if (rdIdx == LAST_SAMPLE) begin
                    // frame drained, open up for the next one
                    inValid <= 1'b0;
                    full    <= 1'b0;
                    rdIdx   <= '0;
                end else begin
                    rdIdx <= nextIdx;
                end
            end else if (loadEn) begin
                inValid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/sampleOutBuf.sv
`timescale 1ns/1ps
`default_nettype none

`include "accelBuf_params.svh"

module sampleOutBuf import accelPkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire cplxSample_t outSample,
    input  wire logic        outValid,
    output      logic        outReady,
    output      memBeat_t    memOutData,
    output      logic        memOutValid,
    input  wire logic        memOutReady,
    output      logic        frameDone
);

    localparam int LANES = `ACCEL_BEAT_LANES;
    localparam int LANE_W = $clog2(LANES);
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(LANES - 1);
    localparam beatIdx_t LAST_BEAT = beatIdx_t'(`ACCEL_FRAME_SAMPLES / LANES - 1);

    logic [LANE_W-1:0] laneIdx;
    beatIdx_t          beatCnt;
    logic              sampleIn;
    logic              beatOut;

    // no new samples while a packed beat waits for the memory side
    assign outReady = !memOutValid;
    assign sampleIn = outValid && outReady;
    assign beatOut  = memOutValid && memOutReady;

    // pulse on the last beat of the frame leaving
    assign frameDone = beatOut && (beatCnt == LAST_BEAT);

    always_ff @(posedge clk) begin
        if (sampleIn) begin
            memOutData[laneIdx] <= outSample;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            laneIdx     <= '0;
            beatCnt     <= '0;
            memOutValid <= 1'b0;
        end else begin
            if (sampleIn) begin
                laneIdx <= laneIdx + 1'b1;
                if (laneIdx == LAST_LANE) begin
                    memOutValid <= 1'b1;
                end
            end

            if (beatOut) begin
                memOutValid <= 1'b0;
                // wraps to 0 after the last beat of a frame
                beatCnt     <= beatCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/accelBufTbTasks.svh
`ifndef ACCEL_BUF_TB_TASKS_SVH
`define ACCEL_BUF_TB_TASKS_SVH

// one more cycle spent in a wait, gives up past the limit
task automatic guardWait(inout int cycles, input string what);
    cycles++;
    if (cycles > TIMEOUT) begin
        $display("timeout: no progress while waiting for %s", what);
        errCnt++;
        finishRun();
    end
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
    checkCnt++;
    if (got !== exp) begin
        errCnt++;
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic checkSample(input string name, input cplxSample_t got, input cplxSample_t exp);
    checkCnt++;
    if (got !== exp) begin
        errCnt++;
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic checkResp(input string name, input axilResp_t got, input axilResp_t exp);
    checkCnt++;
    if (got !== exp) begin
        errCnt++;
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic checkReg(input string name, input logic [31:0] got, input logic [31:0] exp,
                        input axilResp_t gotResp, input axilResp_t expResp);
    checkCnt++;
    if (got !== exp) begin
        errCnt++;
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
    checkResp({name, " RRESP"}, gotResp, expResp);
endtask

task automatic axilWrite(input logic [`ACCEL_AXIL_AW-1:0] addr, input logic [31:0] data,
                         output axilResp_t resp);
    logic awHs;
    logic wHs;
    int   cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    axilAwaddr  = addr;
    axilAwvalid = 1'b1;
    axilWdata   = data;
    axilWstrb   = 4'hF;
    axilWvalid  = 1'b1;
    axilBready  = 1'b1;
    // address and data may be taken on different cycles
    while (axilAwvalid || axilWvalid) begin
        @(negedge clk);
        awHs = axilAwvalid && axilAwready;
        wHs  = axilWvalid && axilWready;
        @(posedge clk);
        #1;
        if (awHs) begin
            axilAwvalid = 1'b0;
        end
        if (wHs) begin
            axilWvalid = 1'b0;
        end
        guardWait(cycles, "AWREADY and WREADY");
    end
    cycles = 0;
    @(negedge clk);
    while (!axilBvalid) begin
        guardWait(cycles, "BVALID");
        @(negedge clk);
    end
    resp = axilBresp;
    @(posedge clk);
    #1;
    axilBready = 1'b0;
endtask

task automatic axilRead(input logic [`ACCEL_AXIL_AW-1:0] addr, output logic [31:0] data,
                        output axilResp_t resp);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    axilAraddr  = addr;
    axilArvalid = 1'b1;
    axilRready  = 1'b1;
    @(negedge clk);
    while (!axilArready) begin
        guardWait(cycles, "ARREADY");
        @(negedge clk);
    end
    @(posedge clk);
    #1;
    axilArvalid = 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!axilRvalid) begin
        guardWait(cycles, "RVALID");
        @(negedge clk);
    end
    data = axilRdata;
    resp = axilRresp;
    @(posedge clk);
    #1;
    axilRready = 1'b0;
endtask

`endif

//--- tests/accelBufTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "accelBuf_params.svh"

module accelBufTb import accelPkg::*; ();

    localparam int BEATS    = `ACCEL_FRAME_SAMPLES / `ACCEL_BEAT_LANES;
    localparam int LANES    = `ACCEL_BEAT_LANES;
    localparam int FRAC     = `ACCEL_COEF_FRAC;
    localparam int TIMEOUT  = 5000;
    localparam int NUM_ROWS = 5;

    // one frame per row with stall and ready given in percent
    typedef struct {
        string       name;
        logic [31:0] coefRe;
        logic [31:0] coefIm;
        int          stallPct;
        int          readyPct;
        bit          useDefault;
    } testRow_t;

    logic                      clk;
    logic                      rst;
    memBeat_t                  memInData;
    logic                      memInValid;
    logic                      memInReady;
    memBeat_t                  memOutData;
    logic                      memOutValid;
    logic                      memOutReady;
    logic [`ACCEL_AXIL_AW-1:0] axilAwaddr;
    logic                      axilAwvalid;
    logic                      axilAwready;
    logic [31:0]               axilWdata;
    logic [3:0]                axilWstrb;
    logic                      axilWvalid;
    logic                      axilWready;
    axilResp_t                 axilBresp;
    logic                      axilBvalid;
    logic                      axilBready;
    logic [`ACCEL_AXIL_AW-1:0] axilAraddr;
    logic                      axilArvalid;
    logic                      axilArready;
    logic [31:0]               axilRdata;
    axilResp_t                 axilRresp;
    logic                      axilRvalid;
    logic                      axilRready;

    testRow_t rows [NUM_ROWS];
    memBeat_t inBeats [BEATS];
    memBeat_t expBeats [BEATS];
    integer   seed = 32'he70f6541;
    int       errCnt = 0;
    int       checkCnt = 0;
    int       testCnt = 0;
    int       framesExp = 0;

    `include "accelBufTbTasks.svh"

    accelBufTop i_dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Q1.30 multiply with sums wrapping in 64 bits before shift and truncate
    function automatic cplxSample_t scaleRef(input cplxSample_t s, input logic [31:0] cRe,
                                             input logic [31:0] cIm);
        longint      accRe;
        longint      accIm;
        cplxSample_t r;
        accRe = longint'(s.re) * longint'($signed(cRe)) - longint'(s.im) * longint'($signed(cIm));
        accIm = longint'(s.re) * longint'($signed(cIm)) + longint'(s.im) * longint'($signed(cRe));
        r.re = 32'(accRe >>> FRAC);
        r.im = 32'(accIm >>> FRAC);
        return r;
    endfunction

    task automatic makeFrame(input testRow_t row);
        for (int b = 0; b < BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                inBeats[b][l].re = $random(seed);
                inBeats[b][l].im = $random(seed);
                expBeats[b][l] = row.useDefault ? inBeats[b][l]
                               : scaleRef(inBeats[b][l], row.coefRe, row.coefIm);
            end
        end
    endtask

    // beat index only moves on an accepted handshake
    task automatic pushFrame(input int stallPct);
        int sent;
        int cycles;
        sent = 0;
        cycles = 0;
        while (sent < BEATS) begin
            @(posedge clk);
            #1;
            memInData  = inBeats[sent];
            memInValid = ({$random(seed)} % 100) >= stallPct;
            @(negedge clk);
            if (memInValid && memInReady) begin
                sent++;
                cycles = 0;
            end else begin
                guardWait(cycles, "memInReady");
            end
        end
        @(posedge clk);
        #1;
        memInValid = 1'b0;
    endtask

    task automatic collectFrame(input int readyPct);
        int got;
        int cycles;
        got = 0;
        cycles = 0;
        while (got < BEATS) begin
            @(posedge clk);
            #1;
            memOutReady = ({$random(seed)} % 100) < readyPct;
            @(negedge clk);
            if (memOutValid && memOutReady) begin
                for (int l = 0; l < LANES; l++) begin
                    checkSample($sformatf("memOutData beat %0d lane %0d", got, l),
                                memOutData[l], expBeats[got][l]);
                end
                got++;
                cycles = 0;
            end else begin
                guardWait(cycles, "memOutValid");
            end
        end
        @(posedge clk);
        #1;
        memOutReady = 1'b0;
    endtask

    task automatic runRow(input testRow_t row);
        logic [31:0] rdData;
        axilResp_t   resp;
        int          cycles;
        if (!row.useDefault) begin
            axilWrite(`ACCEL_REG_COEF_RE, row.coefRe, resp);
            checkResp("BRESP COEF_RE", resp, OKAY);
            axilWrite(`ACCEL_REG_COEF_IM, row.coefIm, resp);
            checkResp("BRESP COEF_IM", resp, OKAY);
        end
        makeFrame(row);
        axilWrite(`ACCEL_REG_CTRL, 32'h1, resp);
        checkResp("BRESP CTRL", resp, OKAY);
        pushFrame(row.stallPct);
        // output side still held so busy and input full
        axilRead(`ACCEL_REG_STATUS, rdData, resp);
        checkReg("STATUS busy", rdData, 32'h5, resp, OKAY);
        // second start while busy must not add a frame
        axilWrite(`ACCEL_REG_CTRL, 32'h1, resp);
        checkResp("BRESP CTRL busy", resp, OKAY);
        collectFrame(row.readyPct);
        cycles = 0;
        axilRead(`ACCEL_REG_STATUS, rdData, resp);
        while (!rdData[1]) begin
            guardWait(cycles, "STATUS done");
            axilRead(`ACCEL_REG_STATUS, rdData, resp);
        end
        framesExp++;
        checkReg("STATUS done", rdData, 32'h2, resp, OKAY);
        axilRead(`ACCEL_REG_FRAMES, rdData, resp);
        checkReg("FRAMES", rdData, 32'(framesExp), resp, OKAY);
        checkBit("memOutValid", memOutValid, 1'b0);
        checkBit("memInReady", memInReady, 1'b1);
    endtask

    task automatic reportTest(input string name, input int errStart);
        testCnt++;
        if (errCnt == errStart) begin
            $display("test %0d %s: ok", testCnt, name);
        end else begin
            $display("test %0d %s: %0d errors", testCnt, name, errCnt - errStart);
        end
    endtask

    task automatic finishRun();
        $display("tests %0d, checks %0d, errors %0d", testCnt, checkCnt, errCnt);
        if (errCnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        logic [31:0] rdData;
        axilResp_t   resp;
        int          errStart;
        rows[0] = '{"identity frame", 32'h4000_0000, 32'h0000_0000, 0, 100, 1'b1};
        rows[1] = '{"negative coef", 32'hC000_0000, 32'hE000_0000, 0, 100, 1'b0};
        rows[2] = '{"pure rotation", 32'h0000_0000, 32'h4000_0000, 30, 70, 1'b0};
        rows[3] = '{"wrapping coef", 32'h7FFF_FFFF, 32'h8000_0000, 50, 40, 1'b0};
        rows[4] = '{"heavy stalls", 32'hF333_3333, 32'h0CCC_CCCD, 70, 20, 1'b0};
        rst         = 1'b1;
        memInData   = '0;
        memInValid  = 1'b0;
        memOutReady = 1'b0;
        axilAwaddr  = '0;
        axilAwvalid = 1'b0;
        axilWdata   = '0;
        axilWstrb   = '0;
        axilWvalid  = 1'b0;
        axilBready  = 1'b0;
        axilAraddr  = '0;
        axilArvalid = 1'b0;
        axilRready  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        errStart = errCnt;
        checkBit("memInReady", memInReady, 1'b1);
        checkBit("memOutValid", memOutValid, 1'b0);
        checkBit("axilAwready", axilAwready, 1'b1);
        checkBit("axilWready", axilWready, 1'b1);
        checkBit("axilArready", axilArready, 1'b1);
        checkBit("axilBvalid", axilBvalid, 1'b0);
        checkBit("axilRvalid", axilRvalid, 1'b0);
        axilRead(`ACCEL_REG_STATUS, rdData, resp);
        checkReg("STATUS", rdData, 32'h0, resp, OKAY);
        axilRead(`ACCEL_REG_FRAMES, rdData, resp);
        checkReg("FRAMES", rdData, 32'h0, resp, OKAY);
        axilRead(`ACCEL_REG_COEF_RE, rdData, resp);
        checkReg("COEF_RE", rdData, 32'h4000_0000, resp, OKAY);
        axilRead(`ACCEL_REG_COEF_IM, rdData, resp);
        checkReg("COEF_IM", rdData, 32'h0, resp, OKAY);
        reportTest("reset values", errStart);

        for (int t = 0; t < NUM_ROWS; t++) begin
            errStart = errCnt;
            runRow(rows[t]);
            reportTest(rows[t].name, errStart);
        end

        errStart = errCnt;
        axilRead(5'h14, rdData, resp);
        checkReg("unmapped read", rdData, 32'h0, resp, SLVERR);
        axilWrite(5'h14, 32'hFFFF_FFFF, resp);
        checkResp("BRESP unmapped", resp, SLVERR);
        axilWrite(`ACCEL_REG_STATUS, 32'hFFFF_FFFF, resp);
        checkResp("BRESP STATUS", resp, OKAY);
        axilRead(`ACCEL_REG_STATUS, rdData, resp);
        checkReg("STATUS after write", rdData, 32'h2, resp, OKAY);
        axilRead(`ACCEL_REG_FRAMES, rdData, resp);
        checkReg("FRAMES", rdData, 32'(framesExp), resp, OKAY);
        reportTest("register errors", errStart);

        finishRun();
    end

endmodule

`default_nettype wire
